//--- Bender.yml
package:
  name: uart_tx_axil

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_axil_regs.sv
  - rtl/uart_tx_fifo.sv
  - rtl/uart_baud_gen.sv
  - rtl/uart_tx.sv
  - rtl/uart_top.sv
  - target: simulation
    files:
      - sim/tb_uart_top.sv

//--- rtl/uart_axil_regs.sv
// uart_axil_regs: AXI4-Lite slave with config registers, tx byte push and status readback
module uart_axil_regs #(
    parameter int unsigned RESET_BAUD_DIV = 16
) (
    input  logic                   clk,
    input  logic                   nRst,
    // write address and data
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    // write response
    output logic                   bvalid,
    output uart_pkg::axil_resp_t   bresp,
    input  logic                   bready,
    // read
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    output logic [31:0]            rdata,
    output uart_pkg::axil_resp_t   rresp,
    input  logic                   rready,
    // core side
    input  logic [7:0]             fifo_count,
    input  logic                   fifo_full,
    input  logic                   tx_busy,
    output logic                   push,
    output uart_pkg::tx_frame_t    push_frame,
    output uart_pkg::uart_cfg_t    cfg
);
    import uart_pkg::*;

    reg_addr_t    wr_addr;
    reg_addr_t    rd_addr;
    logic         wr_accept;
    logic         rd_accept;
    axil_resp_t   wr_resp;
    axil_resp_t   rd_resp;
    logic [31:0]  rd_data;
    parity_mode_t new_parity;

    assign wr_addr = reg_addr_t'(awaddr);
    assign rd_addr = reg_addr_t'(araddr);

    // ==============================
    // write channel
    // ==============================
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign push_frame = '{data: wdata[7:0], parity: cfg.parity};

    always_comb begin
        wr_resp = resp_okay;
        push    = 1'b0;
        case (wr_addr)
            reg_tx_data: begin
                if (fifo_full) wr_resp = resp_slverr;  // byte dropped
                else push = wr_accept;
            end
            reg_ctrl, reg_baud: wr_resp = resp_okay;
            default: wr_resp = resp_slverr;  // status or unmapped
        endcase
    end

    // unknown encodings fall back to no parity
    always_comb begin
        case (wdata[1:0])
            2'b01:   new_parity = par_even;
            2'b10:   new_parity = par_odd;
            default: new_parity = par_none;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            bvalid       <= 1'b0;
            cfg.baud_div <= 16'(RESET_BAUD_DIV);
            cfg.parity   <= par_none;
        end else begin
            if (wr_accept) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (wr_accept && wr_addr == reg_ctrl && wstrb[0]) cfg.parity <= new_parity;
            if (wr_accept && wr_addr == reg_baud) begin
                if (wstrb[0]) cfg.baud_div[7:0] <= wdata[7:0];
                if (wstrb[1]) cfg.baud_div[15:8] <= wdata[15:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) bresp <= wr_resp;
    end

    // ==============================
    // read channel
    // ==============================
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    always_comb begin
        rd_data = '0;
        rd_resp = resp_okay;
        case (rd_addr)
            reg_status: rd_data = {21'b0, tx_busy, fifo_count == 8'd0, fifo_full, fifo_count};
            reg_ctrl:   rd_data = {30'b0, cfg.parity};
            reg_baud:   rd_data = {16'b0, cfg.baud_div};
            default:    rd_resp = resp_slverr;  // tx_data or unmapped, data stays 0
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) rvalid <= 1'b0;
        else if (rd_accept) rvalid <= 1'b1;
        else if (rready) rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

//--- rtl/uart_baud_gen.sv
// uart_baud_gen: bit-period down-counter that ticks once at the end of every bit time
module uart_baud_gen (
    input  logic        clk,
    input  logic        nRst,
    input  logic        restart,
    input  logic [15:0] baud_div,
    output logic        tick
);
    logic [15:0] cnt;
    logic [15:0] div_q;  // divider held for the whole frame

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cnt   <= 16'd0;
            div_q <= 16'd1;
        end else if (restart) begin
            cnt   <= baud_div - 16'd1;
            div_q <= baud_div;
        end else if (cnt == 16'd0) begin
            cnt <= div_q - 16'd1;
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

    assign tick = (cnt == 16'd0);

endmodule

//--- rtl/uart_pkg.sv
// uart_pkg: shared types, register map and parity rule for the UART transmit subsystem
package uart_pkg;

    // ==============================
    // configuration and frame types
    // ==============================
    typedef enum logic [1:0] {
        par_none = 2'd0,
        par_even = 2'd1,
        par_odd  = 2'd2
    } parity_mode_t;

    typedef struct packed {
        logic [7:0]   data;
        parity_mode_t parity;  // mode latched at write time
    } tx_frame_t;

    typedef struct packed {
        logic [15:0]  baud_div;  // clock cycles per bit
        parity_mode_t parity;
    } uart_cfg_t;

    typedef enum logic [2:0] {
        st_idle, st_start, st_data, st_parity, st_stop
    } tx_state_t;

    // ==============================
    // bus encodings
    // ==============================
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_t;

    typedef enum logic [3:0] {
        reg_tx_data = 4'h0,  // write only
        reg_status  = 4'h4,  // read only
        reg_ctrl    = 4'h8,
        reg_baud    = 4'hC
    } reg_addr_t;

    // set when the byte holds an odd number of ones (even mode)
    function automatic logic parity_bit(input logic [7:0] data, input parity_mode_t mode);
        case (mode)
            par_even: return ^data;
            par_odd:  return ~^data;
            default:  return 1'b0;
        endcase
    endfunction

endpackage

//--- rtl/uart_top.sv
// uart_top: AXI4-Lite controlled UART transmitter with queue, bit timer and serializer
module uart_top #(
    parameter int unsigned FIFO_DEPTH     = 8,
    parameter int unsigned RESET_BAUD_DIV = 16
) (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic [3:0]           awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output logic                 bvalid,
    output uart_pkg::axil_resp_t bresp,
    input  logic                 bready,
    input  logic [3:0]           araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic                 rvalid,
    output logic [31:0]          rdata,
    output uart_pkg::axil_resp_t rresp,
    input  logic                 rready,
    output logic                 txd
);
    import uart_pkg::*;

    tx_frame_t  push_frame;
    tx_frame_t  head;
    uart_cfg_t  cfg;
    logic       push;
    logic       pop;
    logic       not_empty;
    logic       fifo_full;
    logic [7:0] fifo_count;
    logic       restart;
    logic       tick;
    logic       tx_busy;

    uart_axil_regs #(.RESET_BAUD_DIV(RESET_BAUD_DIV)) i_regs (
        .clk, .nRst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bvalid, .bresp, .bready, .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp,
        .rready, .fifo_count, .fifo_full, .tx_busy, .push, .push_frame, .cfg
    );

    uart_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk, .nRst, .push, .push_frame, .pop, .head, .not_empty,
        .full(fifo_full), .count(fifo_count)
    );

    uart_baud_gen i_baud (.clk, .nRst, .restart, .baud_div(cfg.baud_div), .tick);

    uart_tx i_tx (.clk, .nRst, .head, .not_empty, .tick, .pop, .restart, .busy(tx_busy), .txd);

endmodule

//--- rtl/uart_tx.sv
// uart_tx: serializer FSM sending start, eight data bits, optional parity and stop bit
module uart_tx (
    input  logic                clk,
    input  logic                nRst,
    input  uart_pkg::tx_frame_t head,
    input  logic                not_empty,
    input  logic                tick,
    output logic                pop,
    output logic                restart,
    output logic                busy,
    output logic                txd
);
    import uart_pkg::*;

    tx_state_t  state;
    logic [7:0] shift_q;
    logic [2:0] bit_cnt;
    logic       par_q;
    logic       has_par_q;

    // ==============================
    // queue handshake
    // ==============================
    assign pop     = (state == st_idle) && not_empty;
    assign restart = pop;  // bit timer starts with the frame
    assign busy    = (state != st_idle);

    // frame payload captured at pop
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q   <= head.data;
            par_q     <= parity_bit(head.data, head.parity);
            has_par_q <= (head.parity != par_none);
        end else if (tick && (state == st_start || state == st_data)) begin
            shift_q <= shift_q >> 1;  // lsb first
        end
    end

    // ==============================
    // line state machine
    // ==============================
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state   <= st_idle;
            txd     <= 1'b1;
            bit_cnt <= 3'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (pop) begin
                        state <= st_start;
                        txd   <= 1'b0;  // start bit
                    end
                end
                st_start: begin
                    if (tick) begin
                        state   <= st_data;
                        txd     <= shift_q[0];
                        bit_cnt <= 3'd0;
                    end
                end
                st_data: begin
                    if (tick) begin
                        if (bit_cnt == 3'd7) begin
                            if (has_par_q) begin
                                state <= st_parity;
                                txd   <= par_q;
                            end else begin
                                state <= st_stop;
                                txd   <= 1'b1;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                            txd     <= shift_q[0];
                        end
                    end
                end
                st_parity: begin
                    if (tick) begin
                        state <= st_stop;
                        txd   <= 1'b1;
                    end
                end
                st_stop: begin
                    if (tick) state <= st_idle;  // line stays high
                end
                default: begin
                    state <= st_idle;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/uart_tx_fifo.sv
// uart_tx_fifo: circular queue of transmit frames with show-ahead head and occupancy count
module uart_tx_fifo #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                nRst,
    input  logic                push,
    input  uart_pkg::tx_frame_t push_frame,
    input  logic                pop,
    output uart_pkg::tx_frame_t head,
    output logic                not_empty,
    output logic                full,
    output logic [7:0]          count
);
    import uart_pkg::*;

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    tx_frame_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == 8'(FIFO_DEPTH));
    assign not_empty = (count != 8'd0);
    assign do_push   = push && !full;  // push while full is lost
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_frame;
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            count <= 8'd0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 8'd1;
                2'b01:   count <= count - 8'd1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

//--- sim/tb_uart_top.sv
// tb_uart_top: testbench for the AXI4-Lite UART transmitter, checks bus responses and txd frames
module tb_uart_top;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int HS_LIMIT    = 64;     // cycles per handshake
    localparam int IDLE_LIMIT  = 4000;   // idle line cycles before complaining
    localparam int DRAIN_LIMIT = 20000;

    logic        clk;
    logic        nRst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    axil_resp_t  bresp;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axil_resp_t  rresp;
    logic        rready;
    logic        txd;

    tx_frame_t    exp_q[$];   // frames accepted by the DUT, in order
    logic [10:0]  got_q[$];   // raw line bits, start bit in bit 0
    int           n_checks;
    int           n_errors;
    int           cur_baud;
    parity_mode_t cur_parity;
    integer       seed;

    uart_top #(.FIFO_DEPTH(FIFO_DEPTH), .RESET_BAUD_DIV(16)) i_dut (.*);

    always #4 clk = ~clk;

    // ==============================
    // reference and checks
    // ==============================
    function automatic logic [10:0] ref_line_bits(input tx_frame_t f);
        logic [10:0] bits;
        int          ones;
        logic        pbit;
        bits    = '1;  // stop and idle
        bits[0] = 1'b0;
        ones    = 0;
        for (int i = 0; i < 8; i++) begin
            bits[i+1] = f.data[i];
            ones += f.data[i];
        end
        pbit = (ones % 2) == 1;  // even mode sends 1 on an odd count
        if (f.parity == par_odd) pbit = !pbit;
        if (f.parity != par_none) bits[9] = pbit;
        return bits;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s: got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_frame(input string name, input tx_frame_t got, input tx_frame_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s: got data %h parity %s expected data %h parity %s", $time,
                     name, got.data, got.parity.name(), exp.data, exp.parity.name());
        end
    endtask

    // ==============================
    // bus tasks
    // ==============================
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output axil_resp_t resp);
        int n;
        resp = resp_slverr;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        #1;  // ready is combinational on valid
        for (n = 0; n < HS_LIMIT && !(awready && wready); n++) begin
            @(negedge clk);
            #1;
        end
        if (!(awready && wready)) begin
            n_errors++;
            $display("ERROR: write to address %h was never accepted", addr);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            bready  = 1'b0;
            return;
        end
        @(negedge clk);  // accepted on the edge in between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (n = 0; n < HS_LIMIT && !bvalid; n++) @(negedge clk);
        if (!bvalid) begin
            n_errors++;
            $display("ERROR: no write response for address %h", addr);
        end else begin
            resp = bresp;
        end
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output axil_resp_t resp);
        int n;
        data = 'x;
        resp = resp_slverr;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        #1;
        for (n = 0; n < HS_LIMIT && !arready; n++) begin
            @(negedge clk);
            #1;
        end
        if (!arready) begin
            n_errors++;
            $display("ERROR: read of address %h was never accepted", addr);
            arvalid = 1'b0;
            rready  = 1'b0;
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        for (n = 0; n < HS_LIMIT && !rvalid; n++) @(negedge clk);
        if (!rvalid) begin
            n_errors++;
            $display("ERROR: no read data for address %h", addr);
        end else begin
            data = rdata;
            resp = rresp;
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input axil_resp_t exp_resp);
        axil_resp_t resp;
        axi_write(addr, data, strb, resp);
        check_resp($sformatf("bresp addr %h", addr), resp, exp_resp);
    endtask

    task automatic read_expect(input string name, input logic [3:0] addr,
                               input logic [31:0] exp_data, input axil_resp_t exp_resp);
        logic [31:0] data;
        axil_resp_t  resp;
        axi_read(addr, data, resp);
        check_resp({name, " rresp"}, resp, exp_resp);
        check_word({name, " rdata"}, data, exp_data);
    endtask

    task automatic set_baud(input int b);
        write_expect(reg_baud, 32'(b), 4'hf, resp_okay);
        cur_baud = b;
    endtask

    task automatic set_parity(input parity_mode_t p);
        write_expect(reg_ctrl, 32'(p), 4'hf, resp_okay);
        cur_parity = p;
    endtask

    task automatic send_byte(input logic [7:0] data, input axil_resp_t exp_resp);
        axil_resp_t resp;
        axi_write(reg_tx_data, {24'b0, data}, 4'hf, resp);
        check_resp("bresp tx_data", resp, exp_resp);
        if (resp == resp_okay) exp_q.push_back('{data: data, parity: cur_parity});
    endtask

    // waits for every expected frame and then for the serializer to go idle
    task automatic wait_drain();
        logic [31:0] st;
        axil_resp_t  resp;
        int          n;
        for (n = 0; n < DRAIN_LIMIT && (exp_q.size() > 0 || got_q.size() > 0); n++)
            @(negedge clk);
        if (exp_q.size() > 0 || got_q.size() > 0) begin
            n_errors++;
            $display("ERROR: timed out with %0d frames still missing on txd", exp_q.size());
            exp_q.delete();
            got_q.delete();
        end
        st = 32'h400;
        for (n = 0; n < HS_LIMIT && st[10] !== 1'b0; n++) axi_read(reg_status, st, resp);
        if (st[10] !== 1'b0) begin
            n_errors++;
            $display("ERROR: serializer stayed busy after the last frame");
        end
    endtask

    // ==============================
    // line monitor and compare
    // ==============================
    initial begin : line_monitor
        logic [10:0] bits;
        int          baud;
        int          nbits;
        int          idx;
        int          n;
        for (n = 0; n < 64 && nRst !== 1'b1; n++) @(negedge clk);
        forever begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (txd !== 1'b0 && n < IDLE_LIMIT);
            if (txd !== 1'b0) begin
                if (exp_q.size() > got_q.size()) begin
                    n_errors++;
                    $display("ERROR: txd stayed idle while frames were queued");
                end
            end else begin
                baud = cur_baud;  // start seen half a cycle in
                bits = '1;
                repeat (baud / 2) @(negedge clk);
                bits[0] = txd;
                for (int i = 1; i <= 8; i++) begin
                    repeat (baud) @(negedge clk);
                    bits[i] = txd;
                end
                idx   = got_q.size();
                nbits = 10;
                if (idx < exp_q.size() && exp_q[idx].parity != par_none) nbits = 11;
                for (int i = 9; i < nbits; i++) begin
                    repeat (baud) @(negedge clk);
                    bits[i] = txd;
                end
                got_q.push_back(bits);
            end
        end
    end

    initial begin : compare_frames
        logic [10:0] got_bits;
        tx_frame_t   exp_f;
        tx_frame_t   got_f;
        forever begin
            @(negedge clk);
            while (got_q.size() > 0) begin
                got_bits = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("ERROR: byte %h appeared on txd but none was queued", got_bits[8:1]);
                end else begin
                    exp_f      = exp_q.pop_front();
                    got_f.data = got_bits[8:1];
                    if (exp_f.parity == par_none) got_f.parity = par_none;
                    else if (got_bits[9] == ^got_bits[8:1]) got_f.parity = par_even;
                    else got_f.parity = par_odd;
                    check_frame("txd frame", got_f, exp_f);
                    check_word("txd line bits", 32'(got_bits), 32'(ref_line_bits(exp_f)));
                end
            end
        end
    end

    // ==============================
    // stimulus
    // ==============================
    initial begin : main
        logic [7:0] b;
        seed       = 32'hf247bdcc;
        clk        = 1'b0;
        nRst       = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        cur_baud   = 16;
        cur_parity = par_none;
        repeat (16) @(negedge clk);
        nRst = 1'b1;

        @(negedge clk);
        check_word("txd after reset", 32'(txd), 32'd1);
        read_expect("status after reset", reg_status, 32'h0000_0200, resp_okay);
        read_expect("ctrl after reset", reg_ctrl, 32'd0, resp_okay);
        read_expect("baud after reset", reg_baud, 32'd16, resp_okay);

        write_expect(reg_ctrl, 32'd1, 4'hf, resp_okay);
        read_expect("ctrl", reg_ctrl, 32'd1, resp_okay);
        write_expect(reg_ctrl, 32'd2, 4'b0010, resp_okay);  // parity byte masked
        read_expect("ctrl partial", reg_ctrl, 32'd1, resp_okay);
        write_expect(reg_baud, 32'h0000_1234, 4'hf, resp_okay);
        read_expect("baud", reg_baud, 32'h0000_1234, resp_okay);
        write_expect(reg_baud, 32'h0000_56ab, 4'b0001, resp_okay);
        read_expect("baud partial", reg_baud, 32'h0000_12ab, resp_okay);
        set_baud(16);
        set_parity(par_none);

        repeat (4) send_byte(8'($random(seed)), resp_okay);
        wait_drain();

        set_baud(8);
        set_parity(par_even);
        repeat (3) send_byte(8'($random(seed)), resp_okay);
        set_parity(par_odd);  // earlier bytes stay even
        repeat (2) send_byte(8'($random(seed)), resp_okay);
        wait_drain();

        // first byte goes straight to the serializer and the burst then overfills the queue
        set_parity(par_none);
        send_byte(8'($random(seed)), resp_okay);
        for (int i = 0; i < 5; i++) begin
            b = 8'($random(seed));
            send_byte(b, (i < FIFO_DEPTH) ? resp_okay : resp_slverr);
        end
        read_expect("status full", reg_status, 32'h0000_0504, resp_okay);
        wait_drain();

        write_expect(reg_status, 32'h0000_0000, 4'hf, resp_slverr);
        write_expect(4'h2, 32'h0000_005a, 4'hf, resp_slverr);
        read_expect("tx_data read", reg_tx_data, 32'd0, resp_slverr);
        read_expect("unmapped read", 4'h6, 32'd0, resp_slverr);
        read_expect("status at end", reg_status, 32'h0000_0200, resp_okay);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/uart_pkg.sv
rtl/uart_axil_regs.sv
rtl/uart_tx_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_top.sv
sim/tb_uart_top.sv
